// File: list.f
board_pkg.sv
bus_fabric.sv
word_ram.sv
gpio_port.sv
ps2_frame_rx.sv
kbd_interface.sv
board_top.sv
tb_board.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module tb_board -Mdir build
	./build/Vtb_board

clean:
	rm -rf build

// File: tb_board.sv
`timescale 1ns/1ps

module tb_board
	import board_pkg::*;
();

	logic clk = 1'b0;
	logic arst_n;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic ps2_clk;
	logic ps2_dat;
	sd_in_t sd_in;
	sd_out_t sd_out;

	word_t prog_model [2**RAM_ADDR_W];
	word_t vid_model [2**RAM_ADDR_W];
	sd_out_t out_model;
	logic [7:0] key_model [$];
	int ram_idx [$];

	board_top board_top_i (
		.clk_i    (clk),
		.arst_n_i (arst_n),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp),
		.ps2_clk_i(ps2_clk),
		.ps2_dat_i(ps2_dat),
		.sd_in_i  (sd_in),
		.sd_out_o (sd_out)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_sd_out(input sd_out_t got, input sd_out_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t ns: SD output pins are %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Program RAM, video RAM and the two register windows.
	function automatic logic is_mapped(input logic [15:0] byte_adr);
		return byte_adr <= 16'h3FFF || byte_adr >= 16'hC000 ||
			(byte_adr >= 16'hB000 && byte_adr <= 16'hB01F);
	endfunction

	// Holds the request until ack is seen high, then drops it on that edge.
	task automatic run_cycle(input logic we, input logic [15:0] byte_adr, input word_t wdat,
			input logic [1:0] sel, output word_t rdat);
		bus_req_t req;
		int waited;
		int exp_wait;
		logic acked;
		waited = 0;
		acked = 1'b0;
		exp_wait = is_mapped(byte_adr) ? 2 : 1;   // Registered ack, or unmapped at once.
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.adr = byte_adr[15:1];
		req.dat = wdat;
		@(posedge clk);
		bus_req <= req;
		while (!acked && waited < 32) begin
			@(negedge clk);                      // Response is stable here.
			acked = bus_rsp.ack;
			waited++;
		end
		if (!acked) begin
			abort_run($sformatf("Timeout: no bus acknowledge for address %h", byte_adr));
		end
		if (waited != exp_wait) begin
			abort_run($sformatf("Error at %0t ns: ack for %h after %0d cycles, expected %0d",
				$time, byte_adr, waited, exp_wait));
		end
		rdat = bus_rsp.dat;
		@(posedge clk);
		bus_req <= '0;
	endtask

	task automatic bus_write(input logic [15:0] byte_adr, input word_t wdat,
			input logic [1:0] sel);
		word_t ignored;
		run_cycle(1'b1, byte_adr, wdat, sel, ignored);
	endtask

	task automatic bus_read(input logic [15:0] byte_adr, output word_t rdat);
		run_cycle(1'b0, byte_adr, 16'h0000, 2'b11, rdat);
	endtask

	function automatic word_t merge_bytes(input word_t old, input word_t wdat,
			input logic [1:0] sel);
		word_t res;
		res = old;
		if (sel[0]) begin
			res[7:0] = wdat[7:0];
		end
		if (sel[1]) begin
			res[15:8] = wdat[15:8];
		end
		return res;
	endfunction

	function automatic logic [15:0] ram_addr(input logic vid, input int idx);
		return {{2{vid}}, RAM_ADDR_W'(idx), 1'b0};   // 0000 or C000 window.
	endfunction

	// Registers repeat through their 16-byte window.
	function automatic logic [15:0] mirror(input logic [15:0] base);
		return base | {12'h000, 2'($urandom_range(0, 3)), 2'b00};
	endfunction

	task automatic ram_write(input logic vid, input int idx, input word_t wdat,
			input logic [1:0] sel);
		bus_write(ram_addr(vid, idx), wdat, sel);
		if (vid) begin
			vid_model[idx] = merge_bytes(vid_model[idx], wdat, sel);
		end else begin
			prog_model[idx] = merge_bytes(prog_model[idx], wdat, sel);
		end
	endtask

	task automatic verify_rams();
		word_t rd;
		foreach (ram_idx[k]) begin
			bus_read(ram_addr(1'b0, ram_idx[k]), rd);
			check_word(rd, prog_model[ram_idx[k]], "program RAM word");
			bus_read(ram_addr(1'b1, ram_idx[k]), rd);
			check_word(rd, vid_model[ram_idx[k]], "video RAM word");
		end
	endtask

	// Start, eight data bits LSB first, odd parity, stop; 20 clocks per bit.
	task automatic ps2_send(input logic [7:0] data, input logic bad_parity);
		logic [PS2_FRAME_BITS-1:0] frame;
		int i;
		frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		@(posedge clk);
		for (i = 0; i < PS2_FRAME_BITS; i++) begin
			ps2_dat <= frame[i];
			repeat (10) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (10) @(posedge clk);
			ps2_clk <= 1'b1;
		end
		if (!bad_parity && key_model.size() < KBD_FIFO_DEPTH) begin
			key_model.push_back(data);
		end
	endtask

	task automatic read_key();
		word_t rd;
		int polls;
		polls = 0;
		rd = '0;
		while (!rd[0] && polls < 64) begin
			bus_read(mirror(16'hB000), rd);
			polls++;
		end
		if (!rd[0]) begin
			abort_run("Timeout: keyboard status never showed a byte ready");
		end
		bus_read(mirror(16'hB002), rd);
		check_word(rd, {8'h00, key_model.pop_front()}, "key byte");
	endtask

	task automatic expect_no_key();
		word_t rd;
		bus_read(mirror(16'hB000), rd);
		check_flag(rd[0], 1'b0, "keyboard ready flag");
	endtask

	initial begin
		word_t rd;
		word_t wdat;
		logic [15:0] adr;
		sd_in_t pins;
		int idx;
		void'($urandom(32'h8324));
		arst_n  <= 1'b0;
		bus_req <= '0;
		ps2_clk <= 1'b1;
		ps2_dat <= 1'b1;
		sd_in   <= '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		@(negedge clk);
		check_sd_out(sd_out, '0);
		expect_no_key();

		// Same indices in both RAMs so crosstalk would show.
		repeat (24) begin
			idx = $urandom_range(0, 2**RAM_ADDR_W - 1);
			ram_idx.push_back(idx);
			ram_write(1'b0, idx, word_t'($urandom), 2'b11);
			ram_write(1'b1, idx, word_t'($urandom), 2'b11);
		end
		repeat (200) begin
			idx = ram_idx[$urandom_range(0, ram_idx.size() - 1)];
			ram_write(1'($urandom), idx, word_t'($urandom), 2'($urandom));
		end
		verify_rams();

		repeat (60) begin
			if ($urandom_range(0, 1) == 1) begin
				adr = 16'h4000 + 16'($urandom_range(0, 16'h6FFF));   // Up to AFFF.
			end else begin
				adr = 16'hB020 + 16'($urandom_range(0, 16'h0FDF));   // Up to BFFF.
			end
			if ($urandom_range(0, 1) == 1) begin
				bus_write(adr, word_t'($urandom), 2'b11);
				// Low bits of a tested RAM word, so a decode slip would corrupt it.
				idx = ram_idx[$urandom_range(0, ram_idx.size() - 1)];
				bus_write({2'b01, RAM_ADDR_W'(idx), 1'b0}, word_t'($urandom), 2'b11);
			end else begin
				bus_read(adr, rd);
				check_word(rd, '0, "unmapped read");
			end
		end
		verify_rams();

		repeat (20) begin
			wdat = word_t'($urandom);
			bus_write(mirror(16'hB012), wdat, 2'($urandom));
			out_model = sd_out_t'(wdat[3:0]);
			@(negedge clk);
			check_sd_out(sd_out, out_model);
			bus_read(mirror(16'hB012), rd);
			check_word(rd, {12'h000, out_model}, "port output register");
			bus_write(mirror(16'hB010), word_t'($urandom), 2'b11);
			@(negedge clk);
			check_sd_out(sd_out, out_model);
			pins = sd_in_t'(3'($urandom));
			@(posedge clk);
			sd_in <= pins;
			repeat (3) @(posedge clk);
			bus_read(mirror(16'hB010), rd);
			check_word(rd, {13'd0, pins}, "port input register");
		end

		repeat (12) begin
			if ($urandom_range(0, 2) == 0) begin
				ps2_send(8'($urandom), 1'b1);
			end
			ps2_send(8'($urandom), 1'b0);
			read_key();
			expect_no_key();
		end

		// Only the first sixteen fit.
		repeat (20) begin
			ps2_send(8'($urandom), 1'b0);
		end
		repeat (KBD_FIFO_DEPTH) begin
			read_key();
		end
		expect_no_key();
		bus_read(mirror(16'hB002), rd);
		check_word(rd, '0, "key byte from empty FIFO");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: board_top.sv
`timescale 1ns/1ps

module board_top import board_pkg::*; (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  bus_req_t bus_req_i,
	output bus_rsp_t bus_rsp_o,
	input  logic     ps2_clk_i,
	input  logic     ps2_dat_i,
	input  sd_in_t   sd_in_i,
	output sd_out_t  sd_out_o
);

	slave_stb_t stb;
	bus_rsp_t prog_rsp;
	bus_rsp_t vid_rsp;
	bus_rsp_t gpio_rsp;
	bus_rsp_t kbd_rsp;

	bus_fabric bus_fabric_i (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.bus_req_i (bus_req_i),
		.stb_o     (stb),
		.prog_rsp_i(prog_rsp),
		.vid_rsp_i (vid_rsp),
		.gpio_rsp_i(gpio_rsp),
		.kbd_rsp_i (kbd_rsp),
		.bus_rsp_o (bus_rsp_o)
	);

	// Program RAM, 0000-3FFF.
	word_ram #(
		.ADDR_W(RAM_ADDR_W)
	) prog_ram_i (
		.clk_i   (clk_i),
		.arst_n_i(arst_n_i),
		.stb_i   (stb.prog),
		.req_i   (bus_req_i),
		.rsp_o   (prog_rsp)
	);

	// Video RAM, C000-FFFF.
	word_ram #(
		.ADDR_W(RAM_ADDR_W)
	) vid_ram_i (
		.clk_i   (clk_i),
		.arst_n_i(arst_n_i),
		.stb_i   (stb.vid),
		.req_i   (bus_req_i),
		.rsp_o   (vid_rsp)
	);

	gpio_port gpio_port_i (
		.clk_i   (clk_i),
		.arst_n_i(arst_n_i),
		.stb_i   (stb.gpio),
		.req_i   (bus_req_i),
		.sd_in_i (sd_in_i),
		.sd_out_o(sd_out_o),
		.rsp_o   (gpio_rsp)
	);

	kbd_interface kbd_interface_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (stb.kbd),
		.req_i    (bus_req_i),
		.ps2_clk_i(ps2_clk_i),
		.ps2_dat_i(ps2_dat_i),
		.rsp_o    (kbd_rsp)
	);

endmodule

// File: kbd_interface.sv
`timescale 1ns/1ps

module kbd_interface import board_pkg::*; (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     stb_i,
	input  bus_req_t req_i,
	input  logic     ps2_clk_i,
	input  logic     ps2_dat_i,
	output bus_rsp_t rsp_o
);

	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] fifo_mem [KBD_FIFO_DEPTH];
	logic [KBD_PTR_W-1:0] wr_ptr_q;
	logic [KBD_PTR_W-1:0] rd_ptr_q;
	logic [KBD_PTR_W:0] cnt_q;
	logic empty;
	logic full;
	logic push;
	logic pop;
	logic rd_en;
	logic ack_q;
	word_t rdata_q;

	ps2_frame_rx ps2_frame_rx_i (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.ps2_clk_i   (ps2_clk_i),
		.ps2_dat_i   (ps2_dat_i),
		.byte_o      (rx_byte),
		.byte_valid_o(rx_valid)
	);

	assign empty = (cnt_q == '0);
	assign full  = (cnt_q == (KBD_PTR_W+1)'(KBD_FIFO_DEPTH));
	assign rd_en = stb_i & ~ack_q & ~req_i.we;
	assign push  = rx_valid & ~full;                 // Dropped when full.
	assign pop   = rd_en & req_i.adr[0] & ~empty;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q    <= 1'b0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			ack_q <= stb_i & ~ack_q;
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= rx_byte;
		end
		if (rd_en) begin
			if (!req_i.adr[0]) begin
				rdata_q <= {15'd0, ~empty};              // Status, bit 0 is ready.
			end else if (empty) begin
				rdata_q <= '0;
			end else begin
				rdata_q <= {8'd0, fifo_mem[rd_ptr_q]};
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rdata_q;

	a_fifo_bound: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		cnt_q <= (KBD_PTR_W+1)'(KBD_FIFO_DEPTH)
	);

endmodule

// File: ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx import board_pkg::*; (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       ps2_clk_i,
	input  logic       ps2_dat_i,
	output logic [7:0] byte_o,
	output logic       byte_valid_o
);

	logic [1:0] clk_sync_q;
	logic [1:0] dat_sync_q;
	logic clk_prev_q;
	logic fall;
	logic last_bit;
	logic frame_ok;
	logic valid_q;
	logic [PS2_CNT_W-1:0] bit_cnt_q;
	logic [PS2_FRAME_BITS-1:0] shift_q;
	logic [PS2_FRAME_BITS-1:0] frame;
	logic [7:0] byte_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clk_sync_q <= '1;              // Both lines idle high.
			dat_sync_q <= '1;
			clk_prev_q <= 1'b1;
			bit_cnt_q  <= '0;
			valid_q    <= 1'b0;
		end else begin
			clk_sync_q <= {clk_sync_q[0], ps2_clk_i};
			dat_sync_q <= {dat_sync_q[0], ps2_dat_i};
			clk_prev_q <= clk_sync_q[1];
			valid_q    <= fall & last_bit & frame_ok;
			if (fall) begin
				bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
			end
		end
	end

	assign fall     = clk_prev_q & ~clk_sync_q[1];
	assign last_bit = (bit_cnt_q == PS2_CNT_W'(PS2_FRAME_BITS - 1));

	// LSB first, so the start bit ends up in bit 0.
	assign frame = {dat_sync_q[1], shift_q[PS2_FRAME_BITS-1:1]};

	assign frame_ok = ~frame[0] & frame[PS2_FRAME_BITS-1] &
		(^frame[PS2_FRAME_BITS-2:1]);    // Odd parity over data and parity bit.

	always_ff @(posedge clk_i) begin
		if (fall) begin
			shift_q <= frame;
			if (last_bit) begin
				byte_q <= frame[8:1];
			end
		end
	end

	assign byte_o       = byte_q;
	assign byte_valid_o = valid_q;

endmodule

// File: gpio_port.sv
`timescale 1ns/1ps

module gpio_port import board_pkg::*; (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     stb_i,
	input  bus_req_t req_i,
	input  sd_in_t   sd_in_i,
	output sd_out_t  sd_out_o,
	output bus_rsp_t rsp_o
);

	localparam int IN_W  = $bits(sd_in_t);
	localparam int OUT_W = $bits(sd_out_t);

	sd_in_t in_meta_q;
	sd_in_t in_sync_q;
	sd_out_t out_q;
	logic ack_q;
	logic out_wr;

	assign out_wr = stb_i & ack_q & req_i.we & req_i.adr[0];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q     <= 1'b0;
			in_meta_q <= '0;
			in_sync_q <= '0;
			out_q     <= '0;             // Card deselected, clock low.
		end else begin
			ack_q     <= stb_i & ~ack_q;
			in_meta_q <= sd_in_i;
			in_sync_q <= in_meta_q;
			if (out_wr) begin
				out_q <= sd_out_t'(req_i.dat[OUT_W-1:0]);
			end
		end
	end

	// Offset 2 is the output latch, offset 0 the card inputs.
	always_comb begin
		rsp_o.ack = ack_q;
		if (req_i.adr[0]) begin
			rsp_o.dat = {{($bits(word_t) - OUT_W){1'b0}}, out_q};
		end else begin
			rsp_o.dat = {{($bits(word_t) - IN_W){1'b0}}, in_sync_q};
		end
	end

	assign sd_out_o = out_q;

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram import board_pkg::*; #(
	parameter int ADDR_W = RAM_ADDR_W
) (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     stb_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o
);

	word_t mem [2**ADDR_W];
	word_t rdata_q;
	logic ack_q;
	logic rd_en;
	logic wr_en;
	logic [ADDR_W-1:0] addr;

	assign addr  = req_i.adr[ADDR_W-1:0];
	assign rd_en = stb_i & ~ack_q;          // First strobe cycle.
	assign wr_en = stb_i & ack_q & req_i.we;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= stb_i & ~ack_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			if (req_i.sel[0]) begin
				mem[addr][7:0] <= req_i.dat[7:0];
			end
			if (req_i.sel[1]) begin
				mem[addr][15:8] <= req_i.dat[15:8];
			end
		end
		if (rd_en) begin
			rdata_q <= mem[addr];
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rdata_q;

	a_ack_follows_stb: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		$rose(ack_q) |-> $past(stb_i)
	);

endmodule

// File: bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import board_pkg::*; (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  bus_req_t   bus_req_i,
	output slave_stb_t stb_o,
	input  bus_rsp_t   prog_rsp_i,
	input  bus_rsp_t   vid_rsp_i,
	input  bus_rsp_t   gpio_rsp_i,
	input  bus_rsp_t   kbd_rsp_i,
	output bus_rsp_t   bus_rsp_o
);

	localparam int DW = $bits(word_t);

	logic cycle;
	logic any_hit;
	logic [RAM_CMP_W-1:0] ram_tag;
	logic [REG_CMP_W-1:0] reg_tag;

	assign cycle   = bus_req_i.cyc & bus_req_i.stb;
	assign ram_tag = bus_req_i.adr[BUS_ADR_W-1 -: RAM_CMP_W];
	assign reg_tag = bus_req_i.adr[BUS_ADR_W-1 -: REG_CMP_W];

	assign stb_o.prog = cycle & (ram_tag == PROG_BASE);
	assign stb_o.vid  = cycle & (ram_tag == VID_BASE);
	assign stb_o.kbd  = cycle & (reg_tag == KBD_BASE);
	assign stb_o.gpio = cycle & (reg_tag == GPIO_BASE);

	assign any_hit = |stb_o;

	// Nothing decoded, so the cycle ends right away and reads zero.
	assign bus_rsp_o.ack = (stb_o.prog & prog_rsp_i.ack) |
		(stb_o.vid & vid_rsp_i.ack) |
		(stb_o.kbd & kbd_rsp_i.ack) |
		(stb_o.gpio & gpio_rsp_i.ack) |
		(cycle & ~any_hit);

	assign bus_rsp_o.dat = ({DW{stb_o.prog}} & prog_rsp_i.dat) |
		({DW{stb_o.vid}} & vid_rsp_i.dat) |
		({DW{stb_o.kbd}} & kbd_rsp_i.dat) |
		({DW{stb_o.gpio}} & gpio_rsp_i.dat);

	a_stb_onehot: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0(stb_o)
	);

endmodule

// File: board_pkg.sv
package board_pkg;

	localparam int BUS_ADR_W      = 15;                  // Byte address bits 15:1.
	localparam int RAM_ADDR_W     = 13;
	localparam int KBD_FIFO_DEPTH = 16;
	localparam int KBD_PTR_W      = $clog2(KBD_FIFO_DEPTH);
	localparam int PS2_FRAME_BITS = 11;
	localparam int PS2_CNT_W      = $clog2(PS2_FRAME_BITS);

	// Window compare widths, taken from the top of the word address.
	localparam int RAM_CMP_W = 2;
	localparam int REG_CMP_W = 12;

	localparam logic [RAM_CMP_W-1:0] PROG_BASE = 2'b00;    // 0000-3FFF.
	localparam logic [RAM_CMP_W-1:0] VID_BASE  = 2'b11;    // C000-FFFF.
	localparam logic [REG_CMP_W-1:0] KBD_BASE  = 12'hB00;  // B000-B00F.
	localparam logic [REG_CMP_W-1:0] GPIO_BASE = 12'hB01;  // B010-B01F.

	typedef logic [15:0] word_t;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [1:0]           sel;
		logic [BUS_ADR_W-1:0] adr;
		word_t                dat;
	} bus_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} bus_rsp_t;

	typedef struct packed {
		logic prog;
		logic kbd;
		logic gpio;
		logic vid;
	} slave_stb_t;

	// Port bit 3 down to bit 0.
	typedef struct packed {
		logic sd_clk;
		logic mosi;
		logic cs;
		logic led;
	} sd_out_t;

	typedef struct packed {
		logic miso;
		logic wp;
		logic cd;
	} sd_in_t;

endpackage
